// ==== rtl/decode_pkg.sv ====
package decode_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // Major opcodes of RV32I
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    //////////////////////////////
    // Operation and format
    //////////////////////////////

    // NOP must stay at zero, the bubble is an all-zero bundle
    typedef enum logic [5:0] {
        NOP, INVALID, LUI, ADD, SUB,
        SLL, SRL, SRA, XOR, OR, AND,
        SLT, SLTU, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ECALL, EBREAK, MRET, SRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    //////////////////////////////
    // Instruction word
    //////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_view_t;

    // Store and branch immediates are split around rs2/rs1
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
    } instr_u;

    //////////////////////////////
    // Port bundles
    //////////////////////////////

    typedef struct packed {
        instr_u          instruction;
        logic [XLEN-1:0] pc;
        logic            access_fault;
    } fetch_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic jumping;
        logic ctx_switch;
        logic rollback;
        logic jump_misaligned;
    } flush_t;

    typedef struct packed {
        logic [XLEN-1:0]       first;
        logic [XLEN-1:0]       second;
        logic [XLEN-1:0]       third;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instruction;
        op_e                   operation;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [CSR_ADDR_W-1:0] csr_address;
        logic                  illegal;
        logic                  misaligned_fetch;
        logic                  access_fault;
    } exec_t;

endpackage

// ==== rtl/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch
    import decode_pkg::*;
(
    input  fetch_t                fetch_i,
    input  format_e               format_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  retire_t               retire_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [XLEN-1:0]       first_o,
    output logic [XLEN-1:0]       second_o,
    output logic [XLEN-1:0]       third_o
);

    logic [31:0]     word;
    s_view_t         s;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] immediate;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    assign word  = fetch_i.instruction;
    assign s     = fetch_i.instruction.s_view;
    assign rs1_o = fetch_i.instruction.r_view.rs1;
    assign rs2_o = fetch_i.instruction.r_view.rs2;

    //////////////////////////////
    // Immediates
    //////////////////////////////

    assign imm_i = {{21{word[31]}}, word[30:20]};
    assign imm_s = {{20{s.imm_hi[6]}}, s.imm_hi, s.imm_lo};
    assign imm_b = {{20{s.imm_hi[6]}}, s.imm_lo[0], s.imm_hi[5:0], s.imm_lo[4:1], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        unique case (format_i)
            I_TYPE:  immediate = imm_i;
            S_TYPE:  immediate = imm_s;
            B_TYPE:  immediate = imm_b;
            U_TYPE:  immediate = imm_u;
            J_TYPE:  immediate = imm_j;
            default: immediate = '0;
        endcase
    end

    // Retiring value wins over the bank read, x0 never forwards
    assign rs1_data = (retire_i.we && retire_i.rd != '0 && retire_i.rd == rs1_o)
                    ? retire_i.data : rs1_data_i;
    assign rs2_data = (retire_i.we && retire_i.rd != '0 && retire_i.rd == rs2_o)
                    ? retire_i.data : rs2_data_i;

    //////////////////////////////
    // Operand selection
    //////////////////////////////

    assign first_o  = (format_i == U_TYPE || format_i == J_TYPE) ? fetch_i.pc : rs1_data;
    assign second_o = (format_i == R_TYPE || format_i == B_TYPE) ? rs2_data : immediate;
    assign third_o  = (format_i == S_TYPE) ? rs2_data : immediate;

endmodule

// ==== rtl/op_decoder.sv ====
`timescale 1ns/1ps

module op_decoder
    import decode_pkg::*;
(
    input  instr_u  instruction_i,
    output op_e     operation_o,
    output format_e format_o
);

    r_view_t r;
    op_e     op_branch;
    op_e     op_load;
    op_e     op_store;
    op_e     op_imm;
    op_e     op_reg;
    op_e     op_system;

    assign r = instruction_i.r_view;

    //////////////////////////////
    // Sub-tables per opcode
    //////////////////////////////

    always_comb begin
        unique case (r.funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (r.funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (r.funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift amounts sit in rs2, so funct7 only matters for the shifts
    always_comb begin
        unique case ({r.funct7, r.funct3}) inside
            10'b???????000: op_imm = ADD;
            10'b0000000001: op_imm = SLL;
            10'b???????010: op_imm = SLT;
            10'b???????011: op_imm = SLTU;
            10'b???????100: op_imm = XOR;
            10'b0000000101: op_imm = SRL;
            10'b0100000101: op_imm = SRA;
            10'b???????110: op_imm = OR;
            10'b???????111: op_imm = AND;
            default:        op_imm = INVALID;
        endcase
    end

    always_comb begin
        unique case ({r.funct7, r.funct3})
            10'b0000000000: op_reg = ADD;
            10'b0100000000: op_reg = SUB;
            10'b0000000001: op_reg = SLL;
            10'b0000000010: op_reg = SLT;
            10'b0000000011: op_reg = SLTU;
            10'b0000000100: op_reg = XOR;
            10'b0000000101: op_reg = SRL;
            10'b0100000101: op_reg = SRA;
            10'b0000000110: op_reg = OR;
            10'b0000000111: op_reg = AND;
            default:        op_reg = INVALID;
        endcase
    end

    // Privileged ops need the full word above the opcode
    always_comb begin
        unique case ({r.funct7, r.rs2, r.rs1, r.funct3, r.rd}) inside
            25'b0000000000000000000000000: op_system = ECALL;
            25'b0000000000010000000000000: op_system = EBREAK;
            25'b0001000000100000000000000: op_system = SRET;
            25'b0011000000100000000000000: op_system = MRET;
            25'b0001000001010000000000000: op_system = WFI;
            25'b?????????????????001?????: op_system = CSRRW;
            25'b?????????????????010?????: op_system = CSRRS;
            25'b?????????????????011?????: op_system = CSRRC;
            25'b?????????????????101?????: op_system = CSRRWI;
            25'b?????????????????110?????: op_system = CSRRSI;
            25'b?????????????????111?????: op_system = CSRRCI;
            default:                       op_system = INVALID;
        endcase
    end

    //////////////////////////////
    // Operation and format
    //////////////////////////////

    always_comb begin
        unique case (r.opcode)
            OPC_LUI:      operation_o = LUI;
            OPC_AUIPC:    operation_o = ADD;
            OPC_JAL:      operation_o = JAL;
            OPC_JALR:     operation_o = JALR;
            OPC_BRANCH:   operation_o = op_branch;
            OPC_LOAD:     operation_o = op_load;
            OPC_STORE:    operation_o = op_store;
            OPC_OP_IMM:   operation_o = op_imm;
            OPC_OP:       operation_o = op_reg;
            // Only FENCE is defined, it does nothing here
            OPC_MISC_MEM: operation_o = (r.funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   operation_o = op_system;
            default:      operation_o = INVALID;
        endcase
    end

    always_comb begin
        unique case (r.opcode[6:2])
            5'b11001, 5'b00000, 5'b00100: format_o = I_TYPE;
            5'b01000:                     format_o = S_TYPE;
            5'b11000:                     format_o = B_TYPE;
            5'b01101, 5'b00101:           format_o = U_TYPE;
            5'b11011:                     format_o = J_TYPE;
            default:                      format_o = R_TYPE;
        endcase
    end

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
    import decode_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    enable_i,
    input  instr_u  instruction_i,
    input  format_e format_i,
    input  flush_t  flush_i,
    output logic    hazard_o,
    output logic    squash_o,
    output logic    killed_o
);

    r_view_t               r;
    logic [REG_ADDR_W-1:0] locked_rd;
    logic                  locked_store;
    logic                  kill;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_mem;
    logic                  hazard_rs1;
    logic                  hazard_rs2;
    logic                  hazard_mem;

    assign r = instruction_i.r_view;

    //////////////////////////////
    // Kill and hazard
    //////////////////////////////

    assign kill = flush_i.jumping || flush_i.ctx_switch
               || flush_i.rollback || flush_i.jump_misaligned;

    assign use_rs1 = format_i inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE};
    assign use_rs2 = format_i inside {R_TYPE, S_TYPE, B_TYPE};
    assign use_mem = (r.opcode == OPC_LOAD) || (r.opcode == OPC_MISC_MEM);

    assign hazard_rs1 = use_rs1 && locked_rd != '0 && locked_rd == r.rs1;
    assign hazard_rs2 = use_rs2 && locked_rd != '0 && locked_rd == r.rs2;
    assign hazard_mem = use_mem && locked_store;

    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && !kill;
    assign squash_o = hazard_o || kill;

    // Lock follows the instruction that actually moves on to execute
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_rd    <= '0;
            locked_store <= 1'b0;
            killed_o     <= 1'b0;
        end else if (enable_i) begin
            killed_o <= kill;
            if (squash_o) begin
                locked_rd    <= '0;
                locked_store <= 1'b0;
            end else begin
                locked_rd    <= r.rd;
                locked_store <= (r.opcode == OPC_STORE);
            end
        end
    end

endmodule

// ==== rtl/execute_register.sv ====
`timescale 1ns/1ps

module execute_register
    import decode_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic            enable_i,
    input  logic            squash_i,
    input  fetch_t          fetch_i,
    input  op_e             operation_i,
    input  logic [XLEN-1:0] first_i,
    input  logic [XLEN-1:0] second_i,
    input  logic [XLEN-1:0] third_i,
    output exec_t           exec_o
);

    r_view_t r;
    exec_t   bundle;

    assign r = fetch_i.instruction.r_view;

    //////////////////////////////
    // Bundle for execute
    //////////////////////////////

    always_comb begin
        bundle.first            = first_i;
        bundle.second           = second_i;
        bundle.third            = third_i;
        bundle.pc               = fetch_i.pc;
        bundle.instruction      = fetch_i.instruction;
        bundle.operation        = operation_i;
        bundle.rd               = r.rd;
        bundle.rs1              = r.rs1;
        // CSR number occupies the I-type immediate field
        bundle.csr_address      = {r.funct7, r.rs2};
        bundle.illegal          = (operation_i == INVALID);
        bundle.misaligned_fetch = (fetch_i.pc[1:0] != 2'b00);
        bundle.access_fault     = fetch_i.access_fault;
    end

    // A bubble is the all-zero bundle carrying NOP
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exec_o           <= '0;
            exec_o.operation <= NOP;
        end else if (enable_i) begin
            if (squash_i) begin
                exec_o           <= '0;
                exec_o.operation <= NOP;
            end else begin
                exec_o <= bundle;
            end
        end
    end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  fetch_t                fetch_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  retire_t               retire_i,
    input  flush_t                flush_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o,
    output logic                  killed_o,
    output exec_t                 exec_o
);

    op_e             operation;
    format_e         format;
    logic [XLEN-1:0] first;
    logic [XLEN-1:0] second;
    logic [XLEN-1:0] third;
    logic            squash;

    //////////////////////////////
    // Input side
    //////////////////////////////

    operand_fetch operand_fetch_inst (
        .fetch_i    (fetch_i),
        .format_i   (format),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .retire_i   (retire_i),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .first_o    (first),
        .second_o   (second),
        .third_o    (third)
    );

    //////////////////////////////
    // Decode and hazards
    //////////////////////////////

    op_decoder op_decoder_inst (
        .instruction_i (fetch_i.instruction),
        .operation_o   (operation),
        .format_o      (format)
    );

    hazard_unit hazard_unit_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .instruction_i (fetch_i.instruction),
        .format_i      (format),
        .flush_i       (flush_i),
        .hazard_o      (hazard_o),
        .squash_o      (squash),
        .killed_o      (killed_o)
    );

    //////////////////////////////
    // Output side
    //////////////////////////////

    execute_register execute_register_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .squash_i    (squash),
        .fetch_i     (fetch_i),
        .operation_i (operation),
        .first_i     (first),
        .second_i    (second),
        .third_i     (third),
        .exec_o      (exec_o)
    );

endmodule

// ==== verification/decode_stage_properties.sv ====
`timescale 1ns/1ps

module decode_stage_properties
    import decode_pkg::*;
(
    input logic   clk,
    input logic   reset_n,
    input logic   enable_i,
    input logic   squash_i,
    input flush_t flush_i,
    input logic   hazard_i,
    input logic   killed_i,
    input exec_t  exec_i
);

    //////////////////////////////
    // Bubble and hold behavior
    //////////////////////////////

    // Squashed instruction leaves a NOP in execute
    bubble_after_squash: assert property (
        @(posedge clk) disable iff (!reset_n)
        enable_i && squash_i |=> exec_i.operation == NOP
    ) else $error("execute register did not load a bubble after a squash");

    // A kill always wins over a hazard
    no_hazard_on_flush: assert property (
        @(posedge clk) disable iff (!reset_n)
        (|flush_i) |-> !hazard_i
    ) else $error("hazard raised while a flush level was high");

    hold_when_disabled: assert property (
        @(posedge clk) disable iff (!reset_n)
        !enable_i |=> $stable(exec_i) && $stable(killed_i)
    ) else $error("execute bundle changed while enable was low");

endmodule

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb
    import decode_pkg::*;
;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 400;
    // Reset plus test cycles, with about half the test length as margin
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TESTS + NUM_TESTS / 2;

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  enable_i;
    fetch_t                fetch_i;
    logic [XLEN-1:0]       rs1_data_i;
    logic [XLEN-1:0]       rs2_data_i;
    retire_t               retire_i;
    flush_t                flush_i;
    logic [REG_ADDR_W-1:0] rs1_o;
    logic [REG_ADDR_W-1:0] rs2_o;
    logic                  hazard_o;
    logic                  killed_o;
    exec_t                 exec_o;

    // Expected state, written at the falling edge and read 10 ns later
    exec_t                 exp_exec;
    logic                  exp_killed;
    logic                  exp_hazard;
    logic [31:0]           cur_word;
    logic                  checking = 1'b0;

    // Lock model of the previous instruction
    logic [REG_ADDR_W-1:0] locked_rd;
    logic                  locked_store;

    logic [31:0] lcg_state = 32'hed872a78;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          n_hazards = 0;
    int          n_kills = 0;
    int          n_illegal = 0;

    op_e branch_table [8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    op_e load_table   [8] = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    op_e store_table  [8] = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    op_e alu_table    [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    op_e csr_table    [8] = '{INVALID, CSRRW, CSRRS, CSRRC, INVALID, CSRRWI, CSRRSI, CSRRCI};

    decode_stage decode_stage_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable_i   (enable_i),
        .fetch_i    (fetch_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .retire_i   (retire_i),
        .flush_i    (flush_i),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .hazard_o   (hazard_o),
        .killed_o   (killed_o),
        .exec_o     (exec_o)
    );

    bind decode_stage decode_stage_properties decode_stage_properties_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .squash_i (squash),
        .flush_i  (flush_i),
        .hazard_i (hazard_o),
        .killed_i (killed_o),
        .exec_i   (exec_o)
    );

    always #HALF_PERIOD clk = ~clk;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    // Registers mostly in x0..x3 so that hazards and forwarding occur often
    function automatic logic [31:0] random_instruction();
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] priv [5];
        priv = '{32'h00000073, 32'h00100073, 32'h10200073, 32'h30200073, 32'h10500073};
        r = next_random();
        w = next_random();
        case (r[3:0])
            4'd0:        w[6:0] = OPC_LUI;
            4'd1:        w[6:0] = OPC_AUIPC;
            4'd2:        w[6:0] = OPC_JAL;
            4'd3:        w[6:0] = OPC_JALR;
            4'd4:        w[6:0] = OPC_BRANCH;
            4'd5, 4'd6:  w[6:0] = OPC_LOAD;
            4'd7, 4'd8:  w[6:0] = OPC_STORE;
            4'd9, 4'd10: w[6:0] = OPC_OP_IMM;
            4'd11, 4'd12: w[6:0] = OPC_OP;
            4'd13:       w[6:0] = OPC_MISC_MEM;
            4'd14:       w[6:0] = OPC_SYSTEM;
            default:     w[6:0] = w[6:0];
        endcase
        if (!r[4]) w[11:9] = 3'b000;
        if (!r[5]) w[19:17] = 3'b000;
        if (!r[6]) w[24:22] = 3'b000;
        if (!r[7]) w[31:25] = r[8] ? 7'h20 : 7'h00;
        if (r[9] && (w[6:0] == OPC_SYSTEM || w[6:0] == OPC_MISC_MEM)) w[14:12] = 3'b000;
        if (r[10] && w[6:0] == OPC_SYSTEM) w = priv[r[13:11] % 5];
        return w;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic op_e expected_operation(logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        op_e        op;
        f7 = w[31:25];
        f3 = w[14:12];
        op = INVALID;
        case (w[6:0])
            OPC_LUI:      op = LUI;
            OPC_AUIPC:    op = ADD;
            OPC_JAL:      op = JAL;
            OPC_JALR:     op = JALR;
            OPC_BRANCH:   op = branch_table[f3];
            OPC_LOAD:     op = load_table[f3];
            OPC_STORE:    op = store_table[f3];
            OPC_MISC_MEM: op = (f3 == 3'd0) ? NOP : INVALID;
            OPC_OP_IMM: begin
                if (f3 == 3'd1) op = (f7 == 7'h00) ? SLL : INVALID;
                else if (f3 == 3'd5) op = (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                else op = alu_table[f3];
            end
            OPC_OP: begin
                if (f7 == 7'h00) op = alu_table[f3];
                else if (f7 == 7'h20 && f3 == 3'd0) op = SUB;
                else if (f7 == 7'h20 && f3 == 3'd5) op = SRA;
            end
            OPC_SYSTEM: begin
                if (f3 != 3'd0) op = csr_table[f3];
                else if (w == 32'h00000073) op = ECALL;
                else if (w == 32'h00100073) op = EBREAK;
                else if (w == 32'h10200073) op = SRET;
                else if (w == 32'h30200073) op = MRET;
                else if (w == 32'h10500073) op = WFI;
            end
            default: op = INVALID;
        endcase
        return op;
    endfunction

    function automatic format_e expected_format(logic [6:0] opc);
        case (opc[6:2])
            OPC_JALR[6:2], OPC_LOAD[6:2], OPC_OP_IMM[6:2]: return I_TYPE;
            OPC_STORE[6:2]:                                return S_TYPE;
            OPC_BRANCH[6:2]:                               return B_TYPE;
            OPC_LUI[6:2], OPC_AUIPC[6:2]:                  return U_TYPE;
            OPC_JAL[6:2]:                                  return J_TYPE;
            default:                                       return R_TYPE;
        endcase
    endfunction

    function automatic exec_t expected_bundle(fetch_t f, logic [31:0] rs1_data,
                                              logic [31:0] rs2_data, retire_t ret);
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        format_e     fmt;
        exec_t       e;
        w   = f.instruction;
        fmt = expected_format(w[6:0]);
        a   = (ret.we && ret.rd != 5'd0 && ret.rd == w[19:15]) ? ret.data : rs1_data;
        b   = (ret.we && ret.rd != 5'd0 && ret.rd == w[24:20]) ? ret.data : rs2_data;
        case (fmt)
            I_TYPE:  imm = {{20{w[31]}}, w[31:20]};
            S_TYPE:  imm = {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  imm = {w[31:12], 12'h000};
            J_TYPE:  imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: imm = 32'h0;
        endcase
        e.first            = (fmt == U_TYPE || fmt == J_TYPE) ? f.pc : a;
        e.second           = (fmt == R_TYPE || fmt == B_TYPE) ? b : imm;
        e.third            = (fmt == S_TYPE) ? b : imm;
        e.pc               = f.pc;
        e.instruction      = w;
        e.operation        = expected_operation(w);
        e.rd               = w[11:7];
        e.rs1              = w[19:15];
        e.csr_address      = w[31:20];
        e.illegal          = (e.operation == INVALID);
        e.misaligned_fetch = (f.pc[1:0] != 2'b00);
        e.access_fault     = f.access_fault;
        return e;
    endfunction

    function automatic logic expected_hazard(logic [31:0] w);
        format_e fmt;
        logic    rs1_hit;
        logic    rs2_hit;
        logic    mem_hit;
        fmt     = expected_format(w[6:0]);
        rs1_hit = locked_rd != 5'd0 && locked_rd == w[19:15]
               && fmt inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE};
        rs2_hit = locked_rd != 5'd0 && locked_rd == w[24:20]
               && fmt inside {R_TYPE, S_TYPE, B_TYPE};
        mem_hit = locked_store && (w[6:0] == OPC_LOAD || w[6:0] == OPC_MISC_MEM);
        return rs1_hit || rs2_hit || mem_hit;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    //////////////////////////////
    // Driver
    //////////////////////////////

    initial begin
        fetch_t  fetch;
        exec_t   next_exec;
        logic    next_killed;
        logic    hold;
        logic    kill;
        logic    enable;
        logic [31:0] r;
        reset_n    = 1'b0;
        enable_i   = 1'b0;
        fetch_i    = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        retire_i   = '0;
        flush_i    = '0;
        locked_rd    = '0;
        locked_store = 1'b0;
        fetch       = '0;
        next_exec   = '0;
        next_killed = 1'b0;
        hold        = 1'b0;
        exp_exec    = '0;
        exp_killed  = 1'b0;
        exp_hazard  = 1'b0;
        cur_word    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            @(negedge clk);
            exp_exec   = next_exec;
            exp_killed = next_killed;
            r = next_random();
            // A stalled instruction is presented again
            if (!hold) begin
                fetch.instruction = random_instruction();
                fetch.pc = next_random() & 32'hffff_fffc;
                if (r[5:3] == 3'b000) fetch.pc[1:0] = r[1:0];
                fetch.access_fault = (r[9:6] == 4'b0000);
            end
            enable = (r[12:10] != 3'b000);
            enable_i      = enable;
            fetch_i       = fetch;
            flush_i       = (r[15:13] == 3'b000) ? r[19:16] : 4'b0000;
            retire_i.we   = r[20];
            retire_i.rd   = r[21] ? r[28:24] : {3'b000, r[23:22]};
            retire_i.data = next_random();
            rs1_data_i    = next_random();
            rs2_data_i    = next_random();
            cur_word      = fetch.instruction;
            kill       = |flush_i;
            exp_hazard = !kill && expected_hazard(cur_word);
            if (enable) begin
                if (kill || exp_hazard) begin
                    next_exec    = '0;
                    next_exec.operation = NOP;
                    locked_rd    = '0;
                    locked_store = 1'b0;
                end else begin
                    next_exec    = expected_bundle(fetch, rs1_data_i, rs2_data_i, retire_i);
                    locked_rd    = cur_word[11:7];
                    locked_store = (cur_word[6:0] == OPC_STORE);
                    if (next_exec.illegal) n_illegal++;
                end
                next_killed = kill;
                hold        = exp_hazard;
                if (kill) n_kills++;
                if (exp_hazard) n_hazards++;
            end
            checking = 1'b1;
        end
        // Idle inputs so the last capture can be checked
        @(negedge clk);
        exp_exec   = next_exec;
        exp_killed = next_killed;
        enable_i   = 1'b0;
        fetch_i    = '0;
        flush_i    = '0;
        cur_word   = '0;
        exp_hazard = expected_hazard(32'h0);
        @(posedge clk);
        $display("checks %0d, errors %0d, hazards %0d, kills %0d, illegal %0d",
                 checks, errors, n_hazards, n_kills, n_illegal);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    //////////////////////////////
    // Comparison
    //////////////////////////////

    // Mid low phase, registers and combinational paths are all settled
    always @(negedge clk) begin
        #10;
        if (checking) begin
            checks++;
            if (hazard_o !== exp_hazard) report_mismatch("hazard_o", 32'(exp_hazard), 32'(hazard_o));
            if (killed_o !== exp_killed) report_mismatch("killed_o", 32'(exp_killed), 32'(killed_o));
            if (rs1_o !== cur_word[19:15]) report_mismatch("rs1_o", 32'(cur_word[19:15]), 32'(rs1_o));
            if (rs2_o !== cur_word[24:20]) report_mismatch("rs2_o", 32'(cur_word[24:20]), 32'(rs2_o));
            if (exec_o.first !== exp_exec.first)
                report_mismatch("exec_o.first", exp_exec.first, exec_o.first);
            if (exec_o.second !== exp_exec.second)
                report_mismatch("exec_o.second", exp_exec.second, exec_o.second);
            if (exec_o.third !== exp_exec.third)
                report_mismatch("exec_o.third", exp_exec.third, exec_o.third);
            if (exec_o.pc !== exp_exec.pc)
                report_mismatch("exec_o.pc", exp_exec.pc, exec_o.pc);
            if (exec_o.instruction !== exp_exec.instruction)
                report_mismatch("exec_o.instruction", exp_exec.instruction, exec_o.instruction);
            if (exec_o.operation !== exp_exec.operation)
                report_mismatch("exec_o.operation", 32'(exp_exec.operation), 32'(exec_o.operation));
            if (exec_o.rd !== exp_exec.rd)
                report_mismatch("exec_o.rd", 32'(exp_exec.rd), 32'(exec_o.rd));
            if (exec_o.rs1 !== exp_exec.rs1)
                report_mismatch("exec_o.rs1", 32'(exp_exec.rs1), 32'(exec_o.rs1));
            if (exec_o.csr_address !== exp_exec.csr_address)
                report_mismatch("exec_o.csr_address", 32'(exp_exec.csr_address),
                                32'(exec_o.csr_address));
            if (exec_o.illegal !== exp_exec.illegal)
                report_mismatch("exec_o.illegal", 32'(exp_exec.illegal), 32'(exec_o.illegal));
            if (exec_o.misaligned_fetch !== exp_exec.misaligned_fetch)
                report_mismatch("exec_o.misaligned_fetch", 32'(exp_exec.misaligned_fetch),
                                32'(exec_o.misaligned_fetch));
            if (exec_o.access_fault !== exp_exec.access_fault)
                report_mismatch("exec_o.access_fault", 32'(exp_exec.access_fault),
                                32'(exec_o.access_fault));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
rtl/decode_pkg.sv
rtl/operand_fetch.sv
rtl/op_decoder.sv
rtl/hazard_unit.sv
rtl/execute_register.sv
rtl/decode_stage.sv
verification/decode_stage_properties.sv
verification/decode_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
